// File: Makefile
SIM      = verilator
TOP      = support_tb
FILELIST = vlog.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/support_assertions.sv
/* support block checks
   ring response timing, register read-back, interrupt lines and bank pulses */
`timescale 1ns/1ps

module support_assertions (
  input logic                                clk,
  input logic                                rst_n,
  input logic [support_pkg::RING_ADDR_W-1:0] i_cfg_start_addr,
  input logic [support_pkg::RING_ADDR_W-1:0] i_cfg_end_addr,
  input logic [support_pkg::RING_ADDR_W-1:0] i_ring_addr,
  input logic                                i_ring_wr_strb,
  input logic [support_pkg::RING_DATA_W-1:0] i_ring_wr_data,
  input logic                                i_ring_rd_strb,
  input logic [support_pkg::RING_DATA_W-1:0] i_ring_rd_data,
  input logic                                i_ring_ack,
  input logic                                i_ring_err_ack,
  input logic [support_pkg::RING_ADDR_W-1:0] o_ring_addr,
  input logic                                o_ring_wr_strb,
  input logic [support_pkg::RING_DATA_W-1:0] o_ring_wr_data,
  input logic                                o_ring_rd_strb,
  input logic [support_pkg::RING_DATA_W-1:0] o_ring_rd_data,
  input logic                                o_ring_ack,
  input logic                                o_ring_err_ack,
  input logic [31:0]                         i_pipe_stat,
  input logic [support_pkg::N_IM_BANKS-1:0]  i_im_available,
  input logic [support_pkg::N_IM_BANKS-1:0]  o_im_consumed,
  input logic [support_int_pkg::N_INT0-1:0]  i_int0_events,
  input logic [support_int_pkg::N_INT1-1:0]  i_int1_events,
  input logic                                o_int0,
  input logic                                o_int1,
  input logic [31:0]                         o_ctl_config,
  input logic [support_pkg::DF_MUX_W-1:0]    o_df_mux_sel
);
  import support_pkg::*;
  import support_int_pkg::*;

  int unsigned            fail_cnt = 0;
  logic [RING_ADDR_W-1:0] addr_ofs;
  logic [LOCL_ADDR_W-1:0] ofs;
  logic                   in_win;
  logic                   wr_in;
  logic                   rd_in;
  logic                   req_in;
  logic                   pass_in;
  logic                   known;
  logic [N_IM_BANKS-1:0]  cons_in;
  // request as the registers see it, one cycle after the ring
  logic                   wr_d1;
  logic [LOCL_ADDR_W-1:0] ofs_d1;
  logic [RING_DATA_W-1:0] data_d1;
  logic [31:0]            ctl_m;
  logic [DF_MUX_W-1:0]    mux_m;
  logic [N_INT0-1:0]      en0_m;
  logic [N_INT0-1:0]      sts0_m;
  logic [N_INT0-1:0]      clr0;
  logic [N_INT1-1:0]      en1_m;
  logic [N_INT1-1:0]      sts1_m;
  logic [N_INT1-1:0]      clr1;

  task automatic report_failure(input string msg);
    fail_cnt++;
    $error("ERROR %0t: %s", $time, msg);
  endtask

  function automatic logic is_mapped(input logic [LOCL_ADDR_W-1:0] o);
    case (o)
      REG_BLKID_REVID, REG_CTL, REG_DF_MUX, REG_PIPE_STAT, REG_IM_AVAILABLE,
      REG_IM_CONSUMED, REG_INT0_STATUS, REG_INT0_ENABLE, REG_INT1_STATUS,
      REG_INT1_ENABLE: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  assign addr_ofs = i_ring_addr - i_cfg_start_addr;
  assign ofs      = addr_ofs[LOCL_ADDR_W-1:0];
  assign in_win   = (i_ring_addr >= i_cfg_start_addr) && (i_ring_addr <= i_cfg_end_addr);
  assign wr_in    = i_ring_wr_strb && in_win;
  assign rd_in    = i_ring_rd_strb && !i_ring_wr_strb && in_win;
  assign req_in   = wr_in || rd_in;
  assign pass_in  = (i_ring_wr_strb || i_ring_rd_strb || i_ring_ack || i_ring_err_ack) && !req_in;
  assign known    = is_mapped(ofs);
  assign cons_in  = i_ring_wr_data[N_IM_BANKS-1:0];
  assign clr0     = (wr_d1 && ofs_d1 == REG_INT0_STATUS) ? data_d1[N_INT0-1:0] : '0;
  assign clr1     = (wr_d1 && ofs_d1 == REG_INT1_STATUS) ? data_d1[N_INT1-1:0] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_d1   <= 1'b0;
      ofs_d1  <= '0;
      data_d1 <= '0;
      ctl_m   <= '0;
      mux_m   <= '0;
      en0_m   <= '0;
      sts0_m  <= '0;
      en1_m   <= '0;
      sts1_m  <= '0;
    end else begin
      wr_d1   <= wr_in;
      ofs_d1  <= ofs;
      data_d1 <= i_ring_wr_data;
      if (wr_d1 && ofs_d1 == REG_CTL) ctl_m <= data_d1;
      if (wr_d1 && ofs_d1 == REG_DF_MUX) mux_m <= data_d1[DF_MUX_W-1:0];
      if (wr_d1 && ofs_d1 == REG_INT0_ENABLE) en0_m <= data_d1[N_INT0-1:0];
      if (wr_d1 && ofs_d1 == REG_INT1_ENABLE) en1_m <= data_d1[N_INT1-1:0];
      sts0_m <= (sts0_m & ~clr0) | i_int0_events;    // event wins over clear
      sts1_m <= (sts1_m & ~clr1) | i_int1_events;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !o_ring_wr_strb && !o_ring_rd_strb && !o_ring_ack && !o_ring_err_ack &&
               o_im_consumed == '0 && o_ctl_config == '0 && o_df_mux_sel == '0 &&
               !o_int0 && !o_int1)
    else report_failure("outputs not cleared by reset");

  a_resp_3: assert property (@(posedge clk) disable iff (!rst_n)
    $past(req_in, 3) |-> (o_ring_ack ^ o_ring_err_ack) && !o_ring_wr_strb && !o_ring_rd_strb)
    else report_failure("in-window request without a single response after 3 cycles");

  a_ack_mapped: assert property (@(posedge clk) disable iff (!rst_n)
    $past(req_in && known, 3) |-> o_ring_ack)
    else report_failure("mapped offset did not get an ack");

  a_err_unmapped: assert property (@(posedge clk) disable iff (!rst_n)
    $past(req_in && !known, 3) |-> o_ring_err_ack && o_ring_rd_data == '0)
    else report_failure("unmapped offset did not give error ack with zero data");

  a_blkid: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_BLKID_REVID, 3) |-> o_ring_rd_data == 32'h00c4_0001)
    else report_failure("wrong block id and revision");

  a_pass: assert property (@(posedge clk) disable iff (!rst_n)
    $past(pass_in, 3) |-> o_ring_addr == $past(i_ring_addr, 3) &&
      o_ring_wr_strb == $past(i_ring_wr_strb, 3) && o_ring_rd_strb == $past(i_ring_rd_strb, 3) &&
      o_ring_ack == $past(i_ring_ack, 3) && o_ring_err_ack == $past(i_ring_err_ack, 3) &&
      o_ring_wr_data == $past(i_ring_wr_data, 3) && o_ring_rd_data == $past(i_ring_rd_data, 3))
    else report_failure("pass-through slot changed on its way");

  a_ctl_out: assert property (@(posedge clk) disable iff (!rst_n)
    o_ctl_config == ctl_m && o_df_mux_sel == mux_m)
    else report_failure("control or mux output differs from last write");

  a_ctl_rd: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_CTL, 3) |-> o_ring_rd_data == $past(ctl_m, 2))
    else report_failure("control read-back mismatch");

  a_mux_rd: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_DF_MUX, 3) |-> o_ring_rd_data == 32'($past(mux_m, 2)))
    else report_failure("mux select read-back mismatch");

  a_pipe_rd: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_PIPE_STAT, 3) |-> o_ring_rd_data == $past(i_pipe_stat, 2))
    else report_failure("pipeline status read mismatch");

  a_avail_rd: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_IM_AVAILABLE, 3) |->
      o_ring_rd_data == 32'($past(i_im_available, 3)))
    else report_failure("availability read mismatch");

  a_consumed: assert property (@(posedge clk) disable iff (!rst_n)
    o_im_consumed == ($past(wr_in && ofs == REG_IM_CONSUMED, 4) ? $past(cons_in, 4) : '0))
    else report_failure("consumed pulse wrong bits or timing");

  // line follows the masked sticky status, so raise, clear and mask all land here
  a_int0_line: assert property (@(posedge clk) disable iff (!rst_n)
    o_int0 == |(sts0_m & en0_m))
    else report_failure("int0 line does not match status and enable");

  a_int1_line: assert property (@(posedge clk) disable iff (!rst_n)
    o_int1 == |(sts1_m & en1_m))
    else report_failure("int1 line does not match status and enable");

  a_int0_sts_rd: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_INT0_STATUS, 3) |-> o_ring_rd_data == 32'($past(sts0_m, 2)))
    else report_failure("int0 status read mismatch");

  a_int1_sts_rd: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rd_in && ofs == REG_INT1_STATUS, 3) |-> o_ring_rd_data == 32'($past(sts1_m, 2)))
    else report_failure("int1 status read mismatch");

endmodule

// File: dv/support_tb.sv
/* support block testbench
   ring traffic, interrupt events and bank flags, checked by bound assertions */
`timescale 1ns/1ps

module support_tb;
  import support_pkg::*;
  import support_int_pkg::*;

  localparam logic [15:0] WIN_START      = 16'h0140;
  localparam logic [15:0] WIN_END        = 16'h015f;
  localparam int          TIMEOUT_CYCLES = 2000;

  logic                   clk;
  logic                   rst_n;
  logic [RING_ADDR_W-1:0] i_cfg_start_addr;
  logic [RING_ADDR_W-1:0] i_cfg_end_addr;
  logic [RING_ADDR_W-1:0] i_ring_addr;
  logic                   i_ring_wr_strb;
  logic [RING_DATA_W-1:0] i_ring_wr_data;
  logic                   i_ring_rd_strb;
  logic [RING_DATA_W-1:0] i_ring_rd_data;
  logic                   i_ring_ack;
  logic                   i_ring_err_ack;
  logic [RING_ADDR_W-1:0] o_ring_addr;
  logic                   o_ring_wr_strb;
  logic [RING_DATA_W-1:0] o_ring_wr_data;
  logic                   o_ring_rd_strb;
  logic [RING_DATA_W-1:0] o_ring_rd_data;
  logic                   o_ring_ack;
  logic                   o_ring_err_ack;
  logic [31:0]            i_pipe_stat;
  logic [N_IM_BANKS-1:0]  i_im_available;
  logic [N_IM_BANKS-1:0]  o_im_consumed;
  logic [N_INT0-1:0]      i_int0_events;
  logic [N_INT1-1:0]      i_int1_events;
  logic                   o_int0;
  logic                   o_int1;
  logic [31:0]            o_ctl_config;
  logic [DF_MUX_W-1:0]    o_df_mux_sel;
  logic [31:0]            rnd_state;
  int unsigned            cycles;
  int unsigned            fails;

  support_top u_support_top (.*);

  bind support_top support_assertions u_support_assertions (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rnd_state = xorshift(rnd_state);
    return rnd_state;
  endfunction

  // drives one ring slot and clears both event inputs for it
  task automatic ring_slot(input logic [15:0] addr, input logic wr, input logic rd,
                           input logic [1:0] resp, input logic [31:0] data);
    @(posedge clk);
    #5;
    i_ring_addr    = addr;
    i_ring_wr_strb = wr;
    i_ring_rd_strb = rd;
    i_ring_wr_data = data;
    i_ring_rd_data = next_rand();
    i_ring_ack     = resp[1];
    i_ring_err_ack = resp[0];
    i_int0_events  = '0;
    i_int1_events  = '0;
  endtask

  task automatic reg_wr(input logic [4:0] ofs, input logic [31:0] data);
    ring_slot(WIN_START + 16'(ofs), 1'b1, 1'b0, 2'b00, data);
  endtask

  task automatic reg_rd(input logic [4:0] ofs);
    ring_slot(WIN_START + 16'(ofs), 1'b0, 1'b1, 2'b00, 32'h0);
  endtask

  task automatic idle(input int n);
    repeat (n) ring_slot(16'h0000, 1'b0, 1'b0, 2'b00, 32'h0);
  endtask

  task automatic fire_events(input logic [7:0] ev0, input logic [5:0] ev1);
    idle(1);
    i_int0_events = ev0;
    i_int1_events = ev1;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [15:0] addr;
    rnd_state        = 32'h3e23_f4e1;
    cycles           = 0;
    rst_n            = 1'b0;
    i_cfg_start_addr = WIN_START;
    i_cfg_end_addr   = WIN_END;
    i_ring_addr      = '0;
    i_ring_wr_strb   = 1'b0;
    i_ring_wr_data   = '0;
    i_ring_rd_strb   = 1'b0;
    i_ring_rd_data   = '0;
    i_ring_ack       = 1'b0;
    i_ring_err_ack   = 1'b0;
    i_pipe_stat      = '0;
    i_im_available   = '0;
    i_int0_events    = '0;
    i_int1_events    = '0;
    repeat (3) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // identity, then every offset of the window read once
    reg_rd(REG_BLKID_REVID);
    i_pipe_stat = next_rand();
    for (int o = 0; o < 32; o++) reg_rd(5'(o));
    reg_wr(5'd6, next_rand());
    reg_wr(5'd11, next_rand());
    reg_wr(5'd31, next_rand());
    reg_wr(REG_PIPE_STAT, next_rand());    // read only
    reg_wr(REG_BLKID_REVID, next_rand());

    // outside the window, plus upstream responses
    ring_slot(WIN_START - 16'd1, 1'b1, 1'b0, 2'b00, next_rand());
    ring_slot(WIN_END + 16'd1, 1'b0, 1'b1, 2'b00, 32'h0);
    ring_slot(16'hffff, 1'b1, 1'b0, 2'b00, next_rand());
    ring_slot(WIN_START, 1'b0, 1'b0, 2'b10, 32'h0);
    ring_slot(16'h0020, 1'b0, 1'b0, 2'b01, 32'h0);

    repeat (4) begin
      reg_wr(REG_CTL, next_rand());
      reg_rd(REG_CTL);
      reg_wr(REG_DF_MUX, next_rand());
      reg_rd(REG_DF_MUX);
    end

    // enabled events, then a clear racing a new event
    reg_wr(REG_INT0_ENABLE, 32'hff);
    reg_wr(REG_INT1_ENABLE, 32'h3f);
    idle(2);
    r = next_rand();
    fire_events(r[7:0] | 8'h01, r[13:8] | 6'h01);
    idle(2);
    reg_rd(REG_INT0_STATUS);
    reg_rd(REG_INT1_STATUS);
    reg_wr(REG_INT0_STATUS, 32'hff);
    fire_events(8'h04, 6'h02);
    idle(3);
    reg_wr(REG_INT0_STATUS, 32'hff);
    reg_wr(REG_INT1_STATUS, 32'h3f);
    idle(3);

    // masked events stay in status only
    reg_wr(REG_INT0_ENABLE, 32'h0);
    reg_wr(REG_INT1_ENABLE, 32'h0);
    idle(2);
    r = next_rand();
    fire_events(r[7:0] | 8'h80, r[13:8] | 6'h20);
    idle(2);
    reg_rd(REG_INT0_STATUS);
    reg_rd(REG_INT1_STATUS);
    reg_wr(REG_INT0_STATUS, 32'hff);
    reg_wr(REG_INT1_STATUS, 32'h3f);

    repeat (4) begin
      r = next_rand();
      idle(1);
      i_im_available = r[7:0];
      reg_rd(REG_IM_AVAILABLE);
      reg_wr(REG_IM_CONSUMED, {24'h0, r[15:8]});
      reg_wr(REG_IM_CONSUMED, {24'h0, r[23:16]});
      idle(5);
    end

    // mixed traffic with sparse events
    for (int i = 0; i < 400; i++) begin
      r    = next_rand();
      addr = r[12] ? (WIN_START + 16'(r[4:0])) : r[31:16];
      ring_slot(addr, r[9:8] == 2'd1, r[9:8] == 2'd2,
                (r[9:8] == 2'd3) ? {r[10], ~r[10]} : 2'b00, next_rand());
      if (r[11]) begin
        i_int0_events = r[19:12] & r[27:20];
        i_int1_events = r[17:12] & r[25:20];
      end
      if (r[28]) i_im_available = r[31:24];
    end
    idle(8);

    fails = u_support_top.u_support_assertions.fail_cnt;
    $display("assertion failures: %0d, cycles run: %0d", fails, cycles);
    if (fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: logic/event_interrupt.sv
/* event interrupt block
   sticky status, write one to clear, with an enable mask */
`timescale 1ns/1ps

module event_interrupt #(
  parameter int N_INT_BITS = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_ofs,
  input  logic                  i_wr,
  input  logic                  i_rd,
  input  logic [N_INT_BITS-1:0] i_wr_data,
  input  logic [N_INT_BITS-1:0] i_events,
  output logic [N_INT_BITS-1:0] o_rd_data,
  output logic                  o_int
);
  import support_int_pkg::*;

  logic [N_INT_BITS-1:0] status;
  logic [N_INT_BITS-1:0] enable;
  logic [N_INT_BITS-1:0] clr;

  assign clr = (i_wr && i_ofs == INT_OFS_STATUS) ? i_wr_data : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status <= '0;
      enable <= '0;
    end else begin
      status <= (status & ~clr) | i_events;    // new event beats the clear
      if (i_wr && i_ofs == INT_OFS_ENABLE) begin
        enable <= i_wr_data;
      end
    end
  end

  always_comb begin
    o_rd_data = '0;
    if (i_rd) begin
      o_rd_data = (i_ofs == INT_OFS_ENABLE) ? enable : status;
    end
  end

  // disabled bits stay visible in status but never reach the line
  assign o_int = |(status & enable);

endmodule

// File: logic/im_bank_handoff.sv
/* bank handoff
   samples engine bank availability and turns consumed writes
   into single-cycle pulses */
`timescale 1ns/1ps

module im_bank_handoff (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [support_pkg::N_IM_BANKS-1:0] i_im_available,
  output logic [support_pkg::N_IM_BANKS-1:0] o_im_available_q,
  input  logic                               i_consumed_wr,
  input  logic [support_pkg::N_IM_BANKS-1:0] i_consumed_data,
  output logic [support_pkg::N_IM_BANKS-1:0] o_im_consumed
);
  import support_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_im_available_q <= '0;
      o_im_consumed    <= '0;
    end else begin
      o_im_available_q <= i_im_available;    // sampled every cycle
      if (i_consumed_wr) begin
        o_im_consumed <= i_consumed_data;
      end else begin
        o_im_consumed <= {N_IM_BANKS{1'b0}};
      end
    end
  end

endmodule

// File: logic/ring_node.sv
/* register ring stop
   takes in-window requests off the ring and puts the local response
   back into the same slot, three cycles later */
`timescale 1ns/1ps

module ring_node (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [support_pkg::RING_ADDR_W-1:0] i_cfg_start_addr,
  input  logic [support_pkg::RING_ADDR_W-1:0] i_cfg_end_addr,
  input  logic [support_pkg::RING_ADDR_W-1:0] i_ring_addr,
  input  logic                             i_ring_wr_strb,
  input  logic [support_pkg::RING_DATA_W-1:0] i_ring_wr_data,
  input  logic                             i_ring_rd_strb,
  input  logic [support_pkg::RING_DATA_W-1:0] i_ring_rd_data,
  input  logic                             i_ring_ack,
  input  logic                             i_ring_err_ack,
  output logic [support_pkg::RING_ADDR_W-1:0] o_ring_addr,
  output logic                             o_ring_wr_strb,
  output logic [support_pkg::RING_DATA_W-1:0] o_ring_wr_data,
  output logic                             o_ring_rd_strb,
  output logic [support_pkg::RING_DATA_W-1:0] o_ring_rd_data,
  output logic                             o_ring_ack,
  output logic                             o_ring_err_ack,
  output logic [support_pkg::LOCL_ADDR_W-1:0] o_locl_addr,
  output logic                             o_locl_wr_strb,
  output logic                             o_locl_rd_strb,
  output logic [support_pkg::RING_DATA_W-1:0] o_locl_wr_data,
  input  logic [support_pkg::RING_DATA_W-1:0] i_locl_rd_data,
  input  logic                             i_locl_ack,
  input  logic                             i_locl_err_ack
);
  import support_pkg::*;

  slot_e                  kind_in;
  slot_e                  kind1;
  slot_e                  kind2;
  logic [3:0]             ctl1;    // {wr_strb, rd_strb, ack, err_ack}
  logic [3:0]             ctl2;
  logic [RING_ADDR_W-1:0] addr1;
  logic [RING_ADDR_W-1:0] addr2;
  logic [RING_ADDR_W-1:0] locl_ofs;
  logic [RING_DATA_W-1:0] wdata1;
  logic [RING_DATA_W-1:0] wdata2;
  logic [RING_DATA_W-1:0] rdata1;
  logic [RING_DATA_W-1:0] rdata2;
  logic                   in_win;
  logic                   local2;

  assign in_win = (i_ring_addr >= i_cfg_start_addr) && (i_ring_addr <= i_cfg_end_addr);

  always_comb begin
    if (i_ring_wr_strb && in_win) begin
      kind_in = SLOT_LOCAL_WR;
    end else if (i_ring_rd_strb && in_win) begin
      kind_in = SLOT_LOCAL_RD;
    end else if (i_ring_wr_strb || i_ring_rd_strb || i_ring_ack || i_ring_err_ack) begin
      kind_in = SLOT_PASS;
    end else begin
      kind_in = SLOT_IDLE;
    end
  end

  // stage 1 drives the local side for exactly one cycle
  assign locl_ofs       = addr1 - i_cfg_start_addr;
  assign o_locl_addr    = locl_ofs[LOCL_ADDR_W-1:0];
  assign o_locl_wr_strb = (kind1 == SLOT_LOCAL_WR);
  assign o_locl_rd_strb = (kind1 == SLOT_LOCAL_RD);
  assign o_locl_wr_data = wdata1;

  assign local2 = (kind2 == SLOT_LOCAL_RD) || (kind2 == SLOT_LOCAL_WR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kind1          <= SLOT_IDLE;
      kind2          <= SLOT_IDLE;
      ctl1           <= '0;
      ctl2           <= '0;
      o_ring_wr_strb <= 1'b0;
      o_ring_rd_strb <= 1'b0;
      o_ring_ack     <= 1'b0;
      o_ring_err_ack <= 1'b0;
    end else begin
      kind1 <= kind_in;
      ctl1  <= {i_ring_wr_strb, i_ring_rd_strb, i_ring_ack, i_ring_err_ack};
      kind2 <= kind1;
      ctl2  <= ctl1;
      if (local2) begin
        // consumed request turns into a response in its own slot
        o_ring_wr_strb <= 1'b0;
        o_ring_rd_strb <= 1'b0;
        o_ring_ack     <= i_locl_ack;
        o_ring_err_ack <= i_locl_err_ack;
      end else begin
        {o_ring_wr_strb, o_ring_rd_strb, o_ring_ack, o_ring_err_ack} <= ctl2;
      end
    end
  end

  always_ff @(posedge clk) begin
    addr1          <= i_ring_addr;
    wdata1         <= i_ring_wr_data;
    rdata1         <= i_ring_rd_data;
    addr2          <= addr1;
    wdata2         <= wdata1;
    rdata2         <= rdata1;
    o_ring_addr    <= addr2;
    o_ring_wr_data <= wdata2;
    o_ring_rd_data <= local2 ? i_locl_rd_data : rdata2;
  end

endmodule

// File: logic/support_int_pkg.sv
/* interrupt source map for the two event interrupt blocks */

package support_int_pkg;

  localparam int N_INT0 = 8;
  localparam int N_INT1 = 6;

  typedef enum int unsigned {
    ISF_UNCOR_ECC = 0,
    ISF_TLVP      = 1,
    ISF_PROT_ERR  = 2,
    ISF_OVFL      = 3,
    ISF_SYS_STALL = 4,
    OSF_UNCOR_ECC = 5,
    CRC_TLVP_ERR  = 6,    // any crc unit
    SU_UNCOR_ECC  = 7
  } int0_src_e;

  typedef enum int unsigned {
    PREFIX_TLVP_ERR  = 0,
    PREFIX_UNCOR_ECC = 1,
    LZ77_TLVP_ERR    = 2,
    HUF_UNCOR_ECC    = 3,
    XP10D_TLVP_ERR   = 4,
    XP10D_UNCOR_ECC  = 5
  } int1_src_e;

  // low offset bit selects the register inside a block
  localparam logic INT_OFS_STATUS = 1'b0;
  localparam logic INT_OFS_ENABLE = 1'b1;

endpackage

// File: logic/support_pkg.sv
/* support block definitions
   ring widths, local register map and block identity constants */

package support_pkg;

  localparam int RING_ADDR_W = 16;
  localparam int RING_DATA_W = 32;
  localparam int LOCL_ADDR_W = 5;    // offset inside the window

  localparam logic [15:0] BLKID = 16'h00c4;
  localparam logic [15:0] REVID = 16'h0001;

  // banks per engine pair: lz77c [1:0], lz77d [3:2], xp10c [5:4], xp10d [7:6]
  localparam int N_IM_ENGINES = 4;
  localparam int N_IM_BANKS   = 2 * N_IM_ENGINES;  // lo bank on even bit

  localparam int DF_MUX_W = 2;

  typedef enum logic [LOCL_ADDR_W-1:0] {
    REG_BLKID_REVID  = 5'd0,
    REG_CTL          = 5'd1,
    REG_DF_MUX       = 5'd2,
    REG_PIPE_STAT    = 5'd3,    // read only
    REG_IM_AVAILABLE = 5'd4,    // read only
    REG_IM_CONSUMED  = 5'd5,    // write ones to hand banks back
    REG_INT0_STATUS  = 5'd8,
    REG_INT0_ENABLE  = 5'd9,
    REG_INT1_STATUS  = 5'd12,
    REG_INT1_ENABLE  = 5'd13
  } reg_addr_e;

  // what a ring slot carries as it moves through the node
  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_PASS,
    SLOT_LOCAL_RD,
    SLOT_LOCAL_WR
  } slot_e;

endpackage

// File: logic/support_regs.sv
/* support local registers
   offset decode, control and mux registers, interrupt and
   consumed forwarding, registered ack or error ack */
`timescale 1ns/1ps

module support_regs (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [support_pkg::LOCL_ADDR_W-1:0] i_locl_addr,
  input  logic                                i_locl_wr_strb,
  input  logic                                i_locl_rd_strb,
  input  logic [support_pkg::RING_DATA_W-1:0] i_locl_wr_data,
  output logic [support_pkg::RING_DATA_W-1:0] o_locl_rd_data,
  output logic                                o_locl_ack,
  output logic                                o_locl_err_ack,
  input  logic [31:0]                         i_pipe_stat,
  input  logic [support_pkg::N_IM_BANKS-1:0]  i_im_available,
  output logic [31:0]                         o_ctl_config,
  output logic [support_pkg::DF_MUX_W-1:0]    o_df_mux_sel,
  output logic                                o_int0_ofs,
  output logic                                o_int0_wr,
  output logic                                o_int0_rd,
  output logic [support_int_pkg::N_INT0-1:0]  o_int0_wr_data,
  input  logic [support_int_pkg::N_INT0-1:0]  i_int0_rd_data,
  output logic                                o_int1_ofs,
  output logic                                o_int1_wr,
  output logic                                o_int1_rd,
  output logic [support_int_pkg::N_INT1-1:0]  o_int1_wr_data,
  input  logic [support_int_pkg::N_INT1-1:0]  i_int1_rd_data,
  output logic                                o_consumed_wr,
  output logic [support_pkg::N_IM_BANKS-1:0]  o_consumed_data
);
  import support_pkg::*;
  import support_int_pkg::*;

  logic                   strb;
  logic                   hit;
  logic                   int0_sel;
  logic                   int1_sel;
  logic [RING_DATA_W-1:0] rd_mux;
  logic                   cons_wr_q;
  logic [N_IM_BANKS-1:0]  cons_data_q;

  assign strb = i_locl_wr_strb | i_locl_rd_strb;

  always_comb begin
    hit      = 1'b1;
    int0_sel = 1'b0;
    int1_sel = 1'b0;
    rd_mux   = '0;
    case (i_locl_addr)
      REG_BLKID_REVID:  rd_mux = {BLKID, REVID};
      REG_CTL:          rd_mux = o_ctl_config;
      REG_DF_MUX:       rd_mux = RING_DATA_W'(o_df_mux_sel);
      REG_PIPE_STAT:    rd_mux = i_pipe_stat;
      REG_IM_AVAILABLE: rd_mux = RING_DATA_W'(i_im_available);
      REG_IM_CONSUMED:  rd_mux = '0;    // pulses only, nothing held
      REG_INT0_STATUS, REG_INT0_ENABLE: begin
        int0_sel = 1'b1;
        rd_mux   = RING_DATA_W'(i_int0_rd_data);
      end
      REG_INT1_STATUS, REG_INT1_ENABLE: begin
        int1_sel = 1'b1;
        rd_mux   = RING_DATA_W'(i_int1_rd_data);
      end
      default:          hit = 1'b0;
    endcase
  end

  // interrupt blocks see the access in the strobe cycle
  assign o_int0_ofs     = i_locl_addr[0];
  assign o_int0_wr      = i_locl_wr_strb & int0_sel;
  assign o_int0_rd      = i_locl_rd_strb & int0_sel;
  assign o_int0_wr_data = i_locl_wr_data[N_INT0-1:0];
  assign o_int1_ofs     = i_locl_addr[0];
  assign o_int1_wr      = i_locl_wr_strb & int1_sel;
  assign o_int1_rd      = i_locl_rd_strb & int1_sel;
  assign o_int1_wr_data = i_locl_wr_data[N_INT1-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ctl_config   <= '0;
      o_df_mux_sel   <= '0;
      o_locl_ack     <= 1'b0;
      o_locl_err_ack <= 1'b0;
      cons_wr_q      <= 1'b0;
      o_consumed_wr  <= 1'b0;
    end else begin
      if (i_locl_wr_strb && i_locl_addr == REG_CTL) begin
        o_ctl_config <= i_locl_wr_data;
      end
      if (i_locl_wr_strb && i_locl_addr == REG_DF_MUX) begin
        o_df_mux_sel <= i_locl_wr_data[DF_MUX_W-1:0];
      end
      o_locl_ack     <= strb & hit;
      o_locl_err_ack <= strb & ~hit;
      // bank handoff follows once the ring response is on its way
      cons_wr_q      <= i_locl_wr_strb && (i_locl_addr == REG_IM_CONSUMED);
      o_consumed_wr  <= cons_wr_q;
    end
  end

  always_ff @(posedge clk) begin
    o_locl_rd_data  <= i_locl_rd_strb ? rd_mux : '0;
    cons_data_q     <= i_locl_wr_data[N_IM_BANKS-1:0];
    o_consumed_data <= cons_data_q;
  end

endmodule

// File: logic/support_top.sv
/* compression engine support register block
   ring node, local registers, two interrupt blocks and bank handoff */
`timescale 1ns/1ps

module support_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [support_pkg::RING_ADDR_W-1:0] i_cfg_start_addr,
  input  logic [support_pkg::RING_ADDR_W-1:0] i_cfg_end_addr,
  input  logic [support_pkg::RING_ADDR_W-1:0] i_ring_addr,
  input  logic                                i_ring_wr_strb,
  input  logic [support_pkg::RING_DATA_W-1:0] i_ring_wr_data,
  input  logic                                i_ring_rd_strb,
  input  logic [support_pkg::RING_DATA_W-1:0] i_ring_rd_data,
  input  logic                                i_ring_ack,
  input  logic                                i_ring_err_ack,
  output logic [support_pkg::RING_ADDR_W-1:0] o_ring_addr,
  output logic                                o_ring_wr_strb,
  output logic [support_pkg::RING_DATA_W-1:0] o_ring_wr_data,
  output logic                                o_ring_rd_strb,
  output logic [support_pkg::RING_DATA_W-1:0] o_ring_rd_data,
  output logic                                o_ring_ack,
  output logic                                o_ring_err_ack,
  input  logic [31:0]                         i_pipe_stat,
  input  logic [support_pkg::N_IM_BANKS-1:0]  i_im_available,
  output logic [support_pkg::N_IM_BANKS-1:0]  o_im_consumed,
  input  logic [support_int_pkg::N_INT0-1:0]  i_int0_events,
  input  logic [support_int_pkg::N_INT1-1:0]  i_int1_events,
  output logic                                o_int0,
  output logic                                o_int1,
  output logic [31:0]                         o_ctl_config,
  output logic [support_pkg::DF_MUX_W-1:0]    o_df_mux_sel
);
  import support_pkg::*;
  import support_int_pkg::*;

  logic [LOCL_ADDR_W-1:0] locl_addr;
  logic                   locl_wr_strb;
  logic                   locl_rd_strb;
  logic [RING_DATA_W-1:0] locl_wr_data;
  logic [RING_DATA_W-1:0] locl_rd_data;
  logic                   locl_ack;
  logic                   locl_err_ack;
  logic                   int0_ofs;
  logic                   int0_wr;
  logic                   int0_rd;
  logic [N_INT0-1:0]      int0_wr_data;
  logic [N_INT0-1:0]      int0_rd_data;
  logic                   int1_ofs;
  logic                   int1_wr;
  logic                   int1_rd;
  logic [N_INT1-1:0]      int1_wr_data;
  logic [N_INT1-1:0]      int1_rd_data;
  logic                   consumed_wr;
  logic [N_IM_BANKS-1:0]  consumed_data;
  logic [N_IM_BANKS-1:0]  im_available_q;

  ring_node u_ring_node (
    .*,    // ring and window ports share their names
    .o_locl_addr    (locl_addr),
    .o_locl_wr_strb (locl_wr_strb),
    .o_locl_rd_strb (locl_rd_strb),
    .o_locl_wr_data (locl_wr_data),
    .i_locl_rd_data (locl_rd_data),
    .i_locl_ack     (locl_ack),
    .i_locl_err_ack (locl_err_ack)
  );

  support_regs u_support_regs (
    .*,
    .i_locl_addr     (locl_addr),
    .i_locl_wr_strb  (locl_wr_strb),
    .i_locl_rd_strb  (locl_rd_strb),
    .i_locl_wr_data  (locl_wr_data),
    .o_locl_rd_data  (locl_rd_data),
    .o_locl_ack      (locl_ack),
    .o_locl_err_ack  (locl_err_ack),
    .i_im_available  (im_available_q),    // sampled copy, not the raw input
    .o_int0_ofs      (int0_ofs),
    .o_int0_wr       (int0_wr),
    .o_int0_rd       (int0_rd),
    .o_int0_wr_data  (int0_wr_data),
    .i_int0_rd_data  (int0_rd_data),
    .o_int1_ofs      (int1_ofs),
    .o_int1_wr       (int1_wr),
    .o_int1_rd       (int1_rd),
    .o_int1_wr_data  (int1_wr_data),
    .i_int1_rd_data  (int1_rd_data),
    .o_consumed_wr   (consumed_wr),
    .o_consumed_data (consumed_data)
  );

  event_interrupt #(.N_INT_BITS(N_INT0)) u_int0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_ofs     (int0_ofs),
    .i_wr      (int0_wr),
    .i_rd      (int0_rd),
    .i_wr_data (int0_wr_data),
    .i_events  (i_int0_events),
    .o_rd_data (int0_rd_data),
    .o_int     (o_int0)
  );

  event_interrupt #(.N_INT_BITS(N_INT1)) u_int1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_ofs     (int1_ofs),
    .i_wr      (int1_wr),
    .i_rd      (int1_rd),
    .i_wr_data (int1_wr_data),
    .i_events  (i_int1_events),
    .o_rd_data (int1_rd_data),
    .o_int     (o_int1)
  );

  im_bank_handoff u_im_bank_handoff (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_im_available   (i_im_available),
    .o_im_available_q (im_available_q),
    .i_consumed_wr    (consumed_wr),
    .i_consumed_data  (consumed_data),
    .o_im_consumed    (o_im_consumed)
  );

endmodule

// File: vlog.f
logic/support_pkg.sv
logic/support_int_pkg.sv
logic/ring_node.sv
logic/support_regs.sv
logic/event_interrupt.sv
logic/im_bank_handoff.sv
logic/support_top.sv
dv/support_assertions.sv
dv/support_tb.sv
